// File: jvm_pkg.sv
`default_nettype none

package jvm_pkg;

    typedef logic [31:0]        word_t;     // stack and ALU data word
    typedef logic [7:0]         opcode_t;
    typedef logic signed [15:0] offset_t;   // pc offset reported per instruction
    typedef logic [3:0]         alu_op_t;
    typedef logic [2:0]         cmp_kind_t;

    // ALU operation selects
    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_MUL = 4'd2;
    localparam alu_op_t ALU_AND = 4'd3;
    localparam alu_op_t ALU_OR  = 4'd4;
    localparam alu_op_t ALU_XOR = 4'd5;

    // compare relations, same order as ifeq..ifle
    localparam cmp_kind_t CMP_EQ = 3'd0;
    localparam cmp_kind_t CMP_NE = 3'd1;
    localparam cmp_kind_t CMP_LT = 3'd2;
    localparam cmp_kind_t CMP_GE = 3'd3;
    localparam cmp_kind_t CMP_GT = 3'd4;
    localparam cmp_kind_t CMP_LE = 3'd5;

    // supported opcodes, ranges are anchored on their first member
    localparam opcode_t OP_NOP       = 8'h00;
    localparam opcode_t OP_ICONST_M1 = 8'h02; // up to iconst_5 at 0x08
    localparam opcode_t OP_BIPUSH    = 8'h10;
    localparam opcode_t OP_SIPUSH    = 8'h11;
    localparam opcode_t OP_IADD      = 8'h60;
    localparam opcode_t OP_ISUB      = 8'h64;
    localparam opcode_t OP_IMUL      = 8'h68;
    localparam opcode_t OP_IAND      = 8'h7e;
    localparam opcode_t OP_IOR       = 8'h80;
    localparam opcode_t OP_IXOR      = 8'h82;
    localparam opcode_t OP_IFEQ      = 8'h99; // up to ifle at 0x9e
    localparam opcode_t OP_IF_ICMPEQ = 8'h9f; // up to if_icmple at 0xa4
    localparam opcode_t OP_GOTO      = 8'ha7;

    typedef struct packed {
        opcode_t    opcode;
        logic [7:0] arg1;   // high byte of a short or branch offset
        logic [7:0] arg2;
    } instr_t;

    typedef struct packed {
        logic       is_alu;
        alu_op_t    alu_op;
        logic       is_cmp;
        cmp_kind_t  cmp_kind;
        logic       cmp_two;     // compare against a popped value, not zero
        logic       is_const;
        word_t      const_val;
        logic       is_arg_push; // bipush / sipush
        logic       is_goto;
        logic [1:0] argc;        // argument bytes following the opcode
        logic [1:0] pop_count;
        logic       writes_back;
    } decode_t;

    typedef struct packed {
        logic  push; // 0 = pop
        word_t data;
    } stack_req_t;

endpackage

`default_nettype wire

// File: bytecode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bytecode_decoder import jvm_pkg::*; (
    input  opcode_t opcode,
    output decode_t dec
);

    always_comb begin
        dec = '0; // anything unlisted falls through as nop

        if (opcode inside {[OP_ICONST_M1 : OP_ICONST_M1 + 8'd6]}) begin
            // iconst_m1 maps to -1, iconst_5 to 5
            dec.is_const    = 1'b1;
            dec.const_val   = word_t'(opcode - OP_ICONST_M1) - 32'd1;
            dec.writes_back = 1'b1;
        end else if (opcode inside {[OP_IFEQ : OP_IFEQ + 8'd5]}) begin
            dec.is_cmp    = 1'b1;
            dec.cmp_kind  = cmp_kind_t'(opcode - OP_IFEQ);
            dec.argc      = 2'd2;
            dec.pop_count = 2'd1; // compared against zero
        end else if (opcode inside {[OP_IF_ICMPEQ : OP_IF_ICMPEQ + 8'd5]}) begin
            dec.is_cmp    = 1'b1;
            dec.cmp_kind  = cmp_kind_t'(opcode - OP_IF_ICMPEQ);
            dec.cmp_two   = 1'b1;
            dec.argc      = 2'd2;
            dec.pop_count = 2'd2;
        end else begin
            case (opcode)
                OP_NOP: begin
                    dec.argc = 2'd0;
                end
                OP_BIPUSH: begin
                    dec.is_arg_push = 1'b1;
                    dec.argc        = 2'd1;
                    dec.writes_back = 1'b1;
                end
                OP_SIPUSH: begin
                    dec.is_arg_push = 1'b1;
                    dec.argc        = 2'd2;
                    dec.writes_back = 1'b1;
                end
                OP_IADD, OP_ISUB, OP_IMUL, OP_IAND, OP_IOR, OP_IXOR: begin
                    dec.is_alu      = 1'b1;
                    dec.pop_count   = 2'd2;
                    dec.writes_back = 1'b1;
                    case (opcode)
                        OP_IADD: dec.alu_op = ALU_ADD;
                        OP_ISUB: dec.alu_op = ALU_SUB;
                        OP_IMUL: dec.alu_op = ALU_MUL;
                        OP_IAND: dec.alu_op = ALU_AND;
                        OP_IOR:  dec.alu_op = ALU_OR;
                        default: dec.alu_op = ALU_XOR;
                    endcase
                end
                OP_GOTO: begin
                    dec.is_goto = 1'b1;
                    dec.argc    = 2'd2; // branchbyte1, branchbyte2
                end
                default: begin
                    dec = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu import jvm_pkg::*; (
    input  word_t   operand_a,
    input  word_t   operand_b,
    input  alu_op_t alu_op,
    output word_t   result
);

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = operand_a + operand_b;
            end
            ALU_SUB: begin
                result = operand_a - operand_b; // a was pushed first
            end
            ALU_MUL: begin
                result = operand_a * operand_b; // only the low word goes back on the stack
            end
            ALU_AND: begin
                result = operand_a & operand_b;
            end
            ALU_OR: begin
                result = operand_a | operand_b;
            end
            ALU_XOR: begin
                result = operand_a ^ operand_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: operand_stack.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stack import jvm_pkg::*; #(
    parameter int STACK_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req,
    input  stack_req_t                   req_data,
    output logic                         ack,
    output word_t                        rdata,
    output word_t                        tos,
    output logic [$clog2(STACK_DEPTH):0] depth,
    output logic                         fault
);

    localparam int PTR_W = $clog2(STACK_DEPTH);

    word_t            mem [STACK_DEPTH];
    logic [PTR_W:0]   sp;       // number of valid entries
    logic [PTR_W-1:0] top_idx;  // slot holding the top entry
    logic             full;
    logic             empty;

    assign top_idx = sp[PTR_W-1:0] - 1'b1; // wraps to the last slot when full
    assign full    = (sp == (PTR_W+1)'(STACK_DEPTH));
    assign empty   = (sp == '0);
    assign depth   = sp;
    assign tos     = empty ? '0 : mem[top_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            sp    <= '0;
            ack   <= 1'b0;
            fault <= 1'b0;
        end else begin
            ack <= req; // every request answered next cycle
            if (req) begin
                if (req_data.push) begin
                    if (full) begin
                        fault <= 1'b1; // overflow, push dropped
                    end else begin
                        sp <= sp + 1'b1;
                    end
                end else begin
                    if (empty) begin
                        fault <= 1'b1; // underflow
                    end else begin
                        sp <= sp - 1'b1;
                    end
                end
            end
        end
    end

    // storage and read data
    always_ff @(posedge clk) begin
        if (req && req_data.push && !full) begin
            mem[sp[PTR_W-1:0]] <= req_data.data;
        end
        if (req && !req_data.push) begin
            rdata <= empty ? '0 : mem[top_idx];
        end
    end

    // requester must wait for the acknowledge before the next request
    a_no_req_during_ack: assert property (
        @(posedge clk) disable iff (reset) ack |-> !req
    );

endmodule

`default_nettype wire

// File: exec_control.sv
`timescale 1ns/1ps
`default_nettype none

module exec_control import jvm_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       instr_valid,
    input  instr_t     instr,
    output opcode_t    opcode,
    input  decode_t    dec,
    output word_t      operand_a,
    output word_t      operand_b,
    output alu_op_t    alu_op,
    input  word_t      alu_result,
    output logic       stack_req,
    output stack_req_t stack_req_data,
    input  logic       stack_ack,
    input  word_t      stack_rdata,
    output logic       op_done,
    output offset_t    pc_offset
);

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        POP,
        COMPARE,
        EXEC,
        PUSH,
        DONE
    } state_t;

    state_t     state;
    instr_t     instr_q;
    logic [1:0] pops_left;
    logic       jump;       // branch taken, goto or compare result
    word_t      wb_word;
    word_t      cmp_rhs;
    logic       cmp_true;

    assign opcode  = instr_q.opcode;
    assign alu_op  = dec.alu_op;
    assign op_done = (state == DONE);

    // single operand compares test against zero
    assign cmp_rhs = dec.cmp_two ? operand_b : '0;

    always_comb begin
        case (dec.cmp_kind)
            CMP_EQ:  cmp_true = (operand_a == cmp_rhs);
            CMP_NE:  cmp_true = (operand_a != cmp_rhs);
            CMP_LT:  cmp_true = ($signed(operand_a) <  $signed(cmp_rhs));
            CMP_GE:  cmp_true = ($signed(operand_a) >= $signed(cmp_rhs));
            CMP_GT:  cmp_true = ($signed(operand_a) >  $signed(cmp_rhs));
            CMP_LE:  cmp_true = ($signed(operand_a) <= $signed(cmp_rhs));
            default: cmp_true = 1'b0;
        endcase
    end

    // value pushed back by constant, literal and ALU instructions
    always_comb begin
        if (dec.is_const) begin
            wb_word = dec.const_val;
        end else if (dec.is_arg_push && dec.argc == 2'd1) begin
            wb_word = {{24{instr_q.arg1[7]}}, instr_q.arg1};
        end else if (dec.is_arg_push) begin
            wb_word = {{16{instr_q.arg1[7]}}, instr_q.arg1, instr_q.arg2};
        end else if (dec.is_alu) begin
            wb_word = alu_result;
        end else begin
            wb_word = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            stack_req <= 1'b0;
            pops_left <= '0;
            jump      <= 1'b0;
            pc_offset <= '0;
        end else begin
            stack_req <= 1'b0; // strobe, one cycle per request
            case (state)
                IDLE: begin
                    if (instr_valid) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    jump      <= dec.is_goto;
                    pops_left <= dec.pop_count;
                    if (dec.pop_count != 2'd0) begin
                        stack_req <= 1'b1;
                        state     <= POP;
                    end else begin
                        state <= EXEC;
                    end
                end
                POP: begin
                    if (stack_ack) begin
                        pops_left <= pops_left - 1'b1;
                        if (pops_left == 2'd1) begin
                            state <= dec.is_cmp ? COMPARE : EXEC;
                        end else begin
                            stack_req <= 1'b1; // fetch operand_a next
                        end
                    end
                end
                COMPARE: begin
                    jump  <= cmp_true;
                    state <= EXEC;
                end
                EXEC: begin
                    if (jump) begin
                        pc_offset <= offset_t'({instr_q.arg1, instr_q.arg2});
                    end else begin
                        pc_offset <= offset_t'({14'd0, dec.argc}) + 16'sd1;
                    end
                    if (dec.writes_back) begin
                        stack_req <= 1'b1;
                        state     <= PUSH;
                    end else begin
                        state <= DONE;
                    end
                end
                PUSH: begin
                    if (stack_ack) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // instruction latch, operands and request payload
    always_ff @(posedge clk) begin
        if (state == IDLE && instr_valid) begin
            instr_q <= instr;
        end
        if (state == DECODE) begin
            operand_a <= '0;
            operand_b <= '0;
            stack_req_data <= '{push: 1'b0, data: '0};
        end
        if (state == POP && stack_ack) begin
            if (pops_left == 2'd2) begin
                operand_b <= stack_rdata; // first pop is the top entry
            end else begin
                operand_a <= stack_rdata;
            end
        end
        if (state == EXEC) begin
            stack_req_data <= '{push: 1'b1, data: wb_word};
        end
    end

    // driver must hold off until op_done has been seen
    a_valid_only_idle: assert property (
        @(posedge clk) disable iff (reset) instr_valid |-> state == IDLE
    );

    // the stack answers every request on the following cycle
    a_ack_after_req: assert property (
        @(posedge clk) disable iff (reset) stack_req |=> stack_ack
    );

endmodule

`default_nettype wire

// File: jvm_core.sv
`timescale 1ns/1ps
`default_nettype none

module jvm_core import jvm_pkg::*; #(
    parameter int STACK_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         instr_valid,
    input  instr_t                       instr,
    output logic                         op_done,
    output offset_t                      pc_offset,
    output word_t                        tos,
    output logic [$clog2(STACK_DEPTH):0] depth,
    output logic                         stack_fault
);

    opcode_t    opcode;
    decode_t    dec;
    word_t      operand_a;
    word_t      operand_b;
    alu_op_t    alu_op;
    word_t      alu_result;
    logic       stack_req;
    stack_req_t stack_req_data;
    logic       stack_ack;
    word_t      stack_rdata;

    exec_control u_control (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .opcode         (opcode),
        .dec            (dec),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .alu_op         (alu_op),
        .alu_result     (alu_result),
        .stack_req      (stack_req),
        .stack_req_data (stack_req_data),
        .stack_ack      (stack_ack),
        .stack_rdata    (stack_rdata),
        .op_done        (op_done),
        .pc_offset      (pc_offset)
    );

    bytecode_decoder u_decoder (
        .opcode (opcode),
        .dec    (dec)
    );

    int_alu u_alu (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .alu_op    (alu_op),
        .result    (alu_result)
    );

    operand_stack #(
        .STACK_DEPTH (STACK_DEPTH)
    ) u_stack (
        .clk      (clk),
        .reset    (reset),
        .req      (stack_req),
        .req_data (stack_req_data),
        .ack      (stack_ack),
        .rdata    (stack_rdata),
        .tos      (tos),
        .depth    (depth),
        .fault    (stack_fault)
    );

endmodule

`default_nettype wire

// File: jvm_core_tests.svh
task automatic push_short(input logic [15:0] value);
    model_push({{16{value[15]}}, value});
    run_and_check(OP_SIPUSH, value[15:8], value[7:0], 16'sd3);
endtask

task automatic push_byte(input logic [7:0] value);
    model_push({{24{value[7]}}, value});
    run_and_check(OP_BIPUSH, value, 8'h00, 16'sd2);
endtask

// bit 8 set keeps a taken branch apart from the fall-through offset
function automatic offset_t pick_branch();
    word_t r;
    r = lcg_next();
    return offset_t'(r[23:8] | 16'h0100);
endfunction

task automatic zero_branch(input cmp_kind_t kind);
    offset_t br;
    word_t   a;
    br = pick_branch();
    a  = model_pop();
    run_and_check(opcode_t'(OP_IFEQ + kind), br[15:8], br[7:0],
                  cmp_holds(kind, a, '0) ? br : 16'sd3);
endtask

task automatic pair_branch(input cmp_kind_t kind);
    offset_t br;
    word_t   a;
    word_t   b;
    br = pick_branch();
    b  = model_pop();   // top entry is the second operand
    a  = model_pop();
    run_and_check(opcode_t'(OP_IF_ICMPEQ + kind), br[15:8], br[7:0],
                  cmp_holds(kind, a, b) ? br : 16'sd3);
endtask

task automatic alu_step(input opcode_t op);
    word_t a;
    word_t b;
    b = model_pop();
    a = model_pop();
    model_push(alu_model(op, a, b));
    run_and_check(op, 8'h00, 8'h00, 16'sd1);
endtask

task automatic drain_stack();
    while (model_q.size() != 0) begin
        zero_branch(CMP_NE);
    end
endtask

task automatic test_const_push();
    test_name = "const_push";
    for (int k = 0; k < 7; k++) begin
        model_push(word_t'(k - 1)); // iconst_m1 .. iconst_5
        run_and_check(opcode_t'(OP_ICONST_M1 + k), 8'h00, 8'h00, 16'sd1);
    end
    push_byte(8'h85);
    push_byte(8'h7f);
    push_short(16'hff38);
    push_short(16'h8000);
    push_short(16'h1234);
    drain_stack();
endtask

task automatic test_alu_ops();
    opcode_t ops[6];
    word_t   r;
    ops       = '{OP_IADD, OP_ISUB, OP_IMUL, OP_IAND, OP_IOR, OP_IXOR};
    test_name = "alu_ops";
    r = lcg_next();
    push_short(r[31:16]);
    // each result stays on the stack as the next left operand
    for (int round = 0; round < ALU_ROUNDS; round++) begin
        for (int i = 0; i < 6; i++) begin
            r = lcg_next();
            push_short(r[31:16]);
            alu_step(ops[i]);
        end
    end
    drain_stack();
endtask

task automatic test_zero_compare();
    word_t r;
    test_name = "zero_compare";
    for (int k = 0; k < 6; k++) begin
        for (int v = 0; v < 3; v++) begin
            r = lcg_next();
            case (v)
                0: push_short({1'b0, r[30:17], 1'b1}); // positive, never zero
                1: begin
                    model_push('0);
                    run_and_check(opcode_t'(OP_ICONST_M1 + 1), 8'h00, 8'h00, 16'sd1);
                end
                default: push_short({1'b1, r[30:16]});
            endcase
            zero_branch(cmp_kind_t'(k));
        end
    end
endtask

task automatic test_pair_compare();
    word_t       r;
    logic [15:0] neg;
    logic [15:0] pos;
    test_name = "pair_compare";
    for (int k = 0; k < 6; k++) begin
        for (int p = 0; p < 3; p++) begin
            r   = lcg_next();
            neg = {1'b1, r[14:0]};   // unsigned order would say the opposite
            pos = {1'b0, r[30:16]};
            case (p)
                0: begin
                    push_short(pos);
                    push_short(pos);
                end
                1: begin
                    push_short(neg);
                    push_short(pos);
                end
                default: begin
                    push_short(pos);
                    push_short(neg);
                end
            endcase
            pair_branch(cmp_kind_t'(k));
        end
    end
endtask

task automatic test_goto_nop();
    offset_t br;
    test_name = "goto_nop";
    push_short(16'h2a5a);
    br = pick_branch();
    run_and_check(OP_GOTO, br[15:8], br[7:0], br);
    run_and_check(OP_GOTO, 8'hff, 8'hf6, -16'sd10); // backward jump
    run_and_check(OP_NOP, 8'h12, 8'h34, 16'sd1);
    run_and_check(8'hff, 8'h12, 8'h34, 16'sd1);     // unlisted opcode runs as nop
    drain_stack();
endtask

task automatic test_stack_fault();
    test_name = "stack_fault";
    if (model_q.size() != 0) begin
        fail_run("stack not empty at the start of the fault test");
    end
    alu_step(OP_IADD); // both pops underflow
    for (int i = 0; i <= STACK_DEPTH; i++) begin
        push_short(16'(i + 1));
    end
    check_depth("saturated depth", depth_t'(STACK_DEPTH), depth);
    check_flag("sticky fault", 1'b1, stack_fault);
endtask

// File: jvm_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module jvm_core_tb import jvm_pkg::*; ();

    localparam int STACK_DEPTH = 16;
    localparam int DEPTH_W     = $clog2(STACK_DEPTH) + 1;
    localparam int ALU_ROUNDS  = 4;
    // instructions issued over all tests, drains included
    localparam int NUM_INSTR   = 24 + (2 + ALU_ROUNDS * 12) + 36 + 54 + 6 + (STACK_DEPTH + 2);
    localparam int WATCHDOG_NS = (NUM_INSTR * 20 + 10 + 200) * 20; // 20 cycles each, 20 ns clock

    typedef logic [DEPTH_W-1:0] depth_t;

    logic    clk = 1'b0;
    logic    reset;
    logic    instr_valid;
    instr_t  instr;
    logic    op_done;
    offset_t pc_offset;
    word_t   tos;
    depth_t  depth;
    logic    stack_fault;

    word_t   model_q[$];    // reference stack, back entry is the top
    logic    model_fault;
    word_t   lcg_state;
    string   test_name;

    jvm_core #(
        .STACK_DEPTH (STACK_DEPTH)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .op_done     (op_done),
        .pc_offset   (pc_offset),
        .tos         (tos),
        .depth       (depth),
        .stack_fault (stack_fault)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string field, input word_t exp, input word_t act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH %s %s: expected %h actual %h",
                               test_name, field, exp, act));
        end
    endtask

    task automatic check_offset(input string field, input offset_t exp, input offset_t act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH %s %s: expected %0d actual %0d",
                               test_name, field, exp, act));
        end
    endtask

    task automatic check_depth(input string field, input depth_t exp, input depth_t act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH %s %s: expected %0d actual %0d",
                               test_name, field, exp, act));
        end
    endtask

    task automatic check_flag(input string field, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH %s %s: expected %b actual %b",
                               test_name, field, exp, act));
        end
    endtask

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic void model_push(input word_t value);
        if (model_q.size() >= STACK_DEPTH) begin
            model_fault = 1'b1; // overflow, value dropped
        end else begin
            model_q.push_back(value);
        end
    endfunction

    function automatic word_t model_pop();
        if (model_q.size() == 0) begin
            model_fault = 1'b1; // underflow reads as zero
            return '0;
        end
        return model_q.pop_back();
    endfunction

    // signed relations in ifeq..ifle order
    function automatic logic cmp_holds(input cmp_kind_t kind, input word_t a, input word_t b);
        case (kind)
            CMP_EQ:  return a == b;
            CMP_NE:  return a != b;
            CMP_LT:  return $signed(a) < $signed(b);
            CMP_GE:  return $signed(a) >= $signed(b);
            CMP_GT:  return $signed(a) > $signed(b);
            CMP_LE:  return $signed(a) <= $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t alu_model(input opcode_t op, input word_t a, input word_t b);
        case (op)
            OP_IADD: return a + b;
            OP_ISUB: return a - b;
            OP_IMUL: return a * b;  // low word of the product
            OP_IAND: return a & b;
            OP_IOR:  return a | b;
            OP_IXOR: return a ^ b;
            default: return '0;
        endcase
    endfunction

    task automatic issue_instr(input opcode_t op, input logic [7:0] byte1,
                               input logic [7:0] byte2);
        int waited;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= '{opcode: op, arg1: byte1, arg2: byte2};
        @(posedge clk);
        instr_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!op_done && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!op_done) begin
            fail_run($sformatf("op_done never arrived for opcode %h in test %s",
                               op, test_name));
        end
    endtask

    // outputs are compared at the negedge where op_done is high
    task automatic check_state(input offset_t exp_offset);
        word_t exp_tos;
        exp_tos = (model_q.size() == 0) ? '0 : model_q[$];
        check_offset("pc_offset", exp_offset, pc_offset);
        check_word("tos", exp_tos, tos);
        check_depth("depth", depth_t'(model_q.size()), depth);
        check_flag("stack_fault", model_fault, stack_fault);
    endtask

    task automatic run_and_check(input opcode_t op, input logic [7:0] byte1,
                                 input logic [7:0] byte2, input offset_t exp_offset);
        issue_instr(op, byte1, byte2);
        check_state(exp_offset);
    endtask

`include "jvm_core_tests.svh"

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        model_fault = 1'b0;
        lcg_state   = 32'h44fb_29c6;
        test_name   = "reset";
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("op_done", 1'b0, op_done);
        check_state(16'sd0);
        test_const_push();
        test_alu_ops();
        test_zero_compare();
        test_pair_compare();
        test_goto_nop();
        test_stack_fault();
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before all tests finished");
    end

endmodule

`default_nettype wire

// File: jvm_core.f
+incdir+.
jvm_pkg.sv
bytecode_decoder.sv
int_alu.sv
operand_stack.sv
exec_control.sv
jvm_core.sv
jvm_core_tb.sv
